// File: all.f
hw/calc_pkg.sv
hw/key_event_if.sv
hw/key_port.sv
hw/calc_control.sv
hw/calc_alu.sv
hw/operand_store.sv
hw/calculator_top.sv
dv/calculator_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the calculator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -f all.f --top-module calculator_tb

output="$(./obj_dir/Vcalculator_tb)"
echo "$output"

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi

// File: dv/calculator_tb.sv
`timescale 1ns/1ps
`default_nettype none

module calculator_tb
    import calc_pkg::*;
();

    localparam int KEY_PRESSES    = 80;                 // Upper bound over all tests
    localparam int MUL_COUNT      = 4;                  // Multiplies, 33 cycles each
    localparam int READ_COUNT     = 11;                 // Host reads
    localparam int TIMEOUT_CYCLES = KEY_PRESSES * 10 + MUL_COUNT * 40 + READ_COUNT * 10 + 200;

    logic              clk;
    logic              reset;
    logic              key_req;
    logic [KEY_W-1:0]  key_code;
    logic              key_ack;
    logic              mem_req;
    logic [ADDR_W-1:0] mem_addr;
    logic              mem_ack;
    logic [DATA_W-1:0] mem_data;
    logic              complete;
    logic [DISP_W-1:0] display_output;

    logic [15:0] lfsr_state   = 16'd86;                 // Random operand source
    int          cycle_count  = 0;
    int          error_count  = 0;
    int          check_count  = 0;
    int          test_errors  = 0;                      // Mismatches in the running test
    int          tests_run    = 0;
    int          tests_failed = 0;
    string       test_name;

    calculator_top calculator_top_inst (
        .clk            (clk),
        .reset          (reset),
        .key_req        (key_req),
        .key_code       (key_code),
        .key_ack        (key_ack),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_ack        (mem_ack),
        .mem_data       (mem_data),
        .complete       (complete),
        .display_output (display_output)
    );

    always #10 clk = ~clk;                              // 20 ns period

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic random_bits(input int count, output logic [DATA_W-1:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);         // One step per bit
            value      = {value[DATA_W-2:0], lfsr_state[0]};
        end
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("Error at %0d ns: %s is 0x%08h, expected 0x%08h", $time, name, got, expected);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_display(input string name, input logic [DISP_W-1:0] got,
                                 input logic [DISP_W-1:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("Error at %0d ns: %s is 0x%04h, expected 0x%04h", $time, name, got, expected);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        check_count++;
        if (got !== expected) begin
            $display("Error at %0d ns: %s is %b, expected %b", $time, name, got, expected);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        string verdict;
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            verdict = "FAILED";
        end else begin
            verdict = "ok";
        end
        $display("Test %-12s %s (%0d mismatches)", test_name, verdict, test_errors);
    endtask

    // Full four-phase key handshake
    task automatic press_key(input logic [KEY_W-1:0] code);
        @(negedge clk);
        key_req  = 1'b1;
        key_code = code;
        while (!key_ack) @(negedge clk);
        key_req = 1'b0;
        while (key_ack) @(negedge clk);                 // Event taken by now
    endtask

    // Host read handshake
    task automatic read_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        @(negedge clk);
        mem_req  = 1'b1;
        mem_addr = addr;
        while (!mem_ack) @(negedge clk);
        data    = mem_data;                             // Valid with ack
        mem_req = 1'b0;
        while (mem_ack) @(negedge clk);
    endtask

    task automatic check_store(input string name, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] expected);
        logic [DATA_W-1:0] data;
        read_word(addr, data);
        check_word(name, data, expected);
    endtask

    task automatic wait_complete();
        while (!complete) @(negedge clk);
    endtask

    // Decimal entry, display tracks the operand
    task automatic enter_number(input logic [DATA_W-1:0] value);
        logic [KEY_W-1:0]  digits [$];
        logic [KEY_W-1:0]  d;
        logic [DATA_W-1:0] rest;
        logic [DATA_W-1:0] accum;
        rest  = value;
        accum = '0;
        do begin
            digits.push_front(KEY_W'(rest % 10));       // Most significant first
            rest = rest / 10;
        end while (rest != 0);
        while (digits.size() > 0) begin
            d = digits.pop_front();
            press_key(d);
            accum = accum * 10 + DATA_W'(d);
            check_display("display_output", display_output, accum[DISP_W-1:0]);
        end
    endtask

    task automatic run_calc(input logic [DATA_W-1:0] a, input logic [KEY_W-1:0] op_key,
                            input logic [DATA_W-1:0] b);
        enter_number(a);
        press_key(op_key);
        enter_number(b);
        press_key(KEY_EQUAL);
        check_bit("complete", complete, 1'b0);          // Result not ready yet
        wait_complete();
    endtask

    task automatic test_reset_state();
        begin_test("reset");
        check_bit("complete", complete, 1'b0);
        check_bit("key_ack", key_ack, 1'b0);
        check_bit("mem_ack", mem_ack, 1'b0);
        check_display("display_output", display_output, 16'd0);
        check_store("store[result]", ADDR_RESULT, 32'd0);
        end_test();
    endtask

    task automatic test_add();
        begin_test("add");
        run_calc(32'd1234, KEY_ADD, 32'd5678);
        check_display("display_output", display_output, 16'd6912);
        end_test();
    endtask

    task automatic test_sub_clear();
        begin_test("sub_clear");
        enter_number(32'd724);
        press_key(KEY_CLEAR);
        check_display("display_output", display_output, 16'd0);
        run_calc(32'd5, KEY_SUB, 32'd9);
        check_store("store[result]", ADDR_RESULT, 32'hFFFF_FFFC);  // 2^32 - 4
        check_display("display_output", display_output, 16'hFFFC);
        end_test();
    endtask

    task automatic test_multiply();
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] product;
        begin_test("multiply");
        for (int i = 0; i < 3; i++) begin
            random_bits(17, a);
            random_bits(17, b);
            a       = a % 100000;                       // Up to five digits
            b       = b % 100000;
            product = a * b;                            // Low word only
            run_calc(a, KEY_MUL, b);
            check_display("display_output", display_output, product[DISP_W-1:0]);
            check_store("store[result]", ADDR_RESULT, product);
        end
        end_test();
    endtask

    task automatic test_store();
        begin_test("store");
        run_calc(32'd98765, KEY_ADD, 32'd4321);
        check_store("store[operand_a]", ADDR_OPERAND_A, 32'd98765);
        check_store("store[operand_b]", ADDR_OPERAND_B, 32'd4321);
        check_store("store[result]", ADDR_RESULT, 32'd103086);
        press_key(4'd6);                                // New entry after the result
        check_bit("complete", complete, 1'b0);
        check_display("display_output", display_output, 16'd6);
        check_store("store[operand_a]", ADDR_OPERAND_A, 32'd6);
        end_test();
    endtask

    task automatic test_backpressure();
        int waited;
        begin_test("backpressure");
        press_key(KEY_CLEAR);
        enter_number(32'd250);
        press_key(KEY_MUL);
        enter_number(32'd12);
        press_key(KEY_EQUAL);
        @(negedge clk);
        key_req  = 1'b1;                                // Key during the multiply
        key_code = 4'd7;
        waited   = 0;
        while (!key_ack) begin
            @(negedge clk);
            waited++;
        end
        check_bit("complete at key_ack", complete, 1'b1);
        check_bit("key_ack held past multiply", waited > 32, 1'b1);
        key_req = 1'b0;
        while (key_ack) @(negedge clk);
        check_bit("complete", complete, 1'b0);
        check_display("display_output", display_output, 16'd7);
        check_store("store[operand_a]", ADDR_OPERAND_A, 32'd7);
        check_store("store[result]", ADDR_RESULT, 32'd3000);
        end_test();
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        key_req  = 1'b0;
        key_code = '0;
        mem_req  = 1'b0;
        mem_addr = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_state();
        test_add();
        test_sub_clear();
        test_multiply();
        test_store();
        test_backpressure();
        $display("Tests run %0d, failed %0d, checks %0d, mismatches %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/calculator_top.sv
`timescale 1ns/1ps
`default_nettype none

module calculator_top
    import calc_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              key_req,                  // Keypad handshake
    input  logic [KEY_W-1:0]  key_code,
    output logic              key_ack,
    input  logic              mem_req,                  // Host read handshake
    input  logic [ADDR_W-1:0] mem_addr,
    output logic              mem_ack,
    output logic [DATA_W-1:0] mem_data,
    output logic              complete,                 // Result shown
    output logic [DISP_W-1:0] display_output
);

    logic              alu_start;
    calc_op_t          alu_op;
    logic [DATA_W-1:0] operand_a;
    logic [DATA_W-1:0] operand_b;
    logic              alu_done;
    logic [DATA_W-1:0] alu_result;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;

    key_event_if key_events ();                         // Port to controller events

    key_port key_port_inst (
        .clk      (clk),
        .reset    (reset),
        .key_req  (key_req),
        .key_code (key_code),
        .key_ack  (key_ack),
        .events   (key_events.source)
    );

    calc_control calc_control_inst (
        .clk            (clk),
        .reset          (reset),
        .events         (key_events.sink),
        .alu_start      (alu_start),
        .alu_op         (alu_op),
        .operand_a      (operand_a),
        .operand_b      (operand_b),
        .alu_done       (alu_done),
        .alu_result     (alu_result),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .complete       (complete),
        .display_output (display_output)
    );

    calc_alu calc_alu_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (alu_start),
        .op        (alu_op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .done      (alu_done),
        .result    (alu_result)
    );

    operand_store operand_store_inst (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data)
    );

endmodule

`default_nettype wire

// File: hw/operand_store.sv
`timescale 1ns/1ps
`default_nettype none

module operand_store
    import calc_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,                    // Controller write
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic              mem_req,                  // Host read request
    input  logic [ADDR_W-1:0] mem_addr,
    output logic              mem_ack,                  // Host read acknowledge
    output logic [DATA_W-1:0] mem_data                  // Valid while mem_ack high
);

    logic [DATA_W-1:0] mem [STORE_DEPTH];
    logic              rd_fire;                         // Host read uses the port

    // Controller wins the single port
    assign rd_fire = mem_req && !mem_ack && !wr_en;

    // Clean store at power up
    initial begin
        for (int i = 0; i < STORE_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Single port array access
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end else if (rd_fire) begin
            mem_data <= mem[mem_addr];                  // Held until the next read
        end
    end

    // Host handshake
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_ack <= 1'b0;
        end else if (rd_fire) begin
            mem_ack <= 1'b1;                            // Data ready with ack
        end else if (mem_ack && !mem_req) begin
            mem_ack <= 1'b0;                            // Release after req drops
        end
    end

endmodule

`default_nettype wire

// File: hw/calc_alu.sv
`timescale 1ns/1ps
`default_nettype none

module calc_alu
    import calc_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              start,                    // One cycle request
    input  calc_op_t          op,
    input  logic [DATA_W-1:0] operand_a,
    input  logic [DATA_W-1:0] operand_b,
    output logic              done,                     // One cycle completion pulse
    output logic [DATA_W-1:0] result
);

    logic              busy;                            // Multiply loop running
    logic [4:0]        step_count;                      // Multiply iteration index
    logic [DATA_W-1:0] mcand;                           // Shifted multiplicand
    logic [DATA_W-1:0] mplier;                          // Remaining multiplier bits

    // Control state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy       <= 1'b0;
            step_count <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy       <= (op == OP_MUL);
                step_count <= '0;
                done       <= (op != OP_MUL);           // Add and sub done next cycle
            end else if (busy) begin
                step_count <= step_count + 5'd1;
                if (step_count == 5'd31) begin
                    busy <= 1'b0;                       // Last of 32 steps
                    done <= 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= operand_a;
            mplier <= operand_b;
            if (op == OP_SUB) begin
                result <= operand_a - operand_b;        // Wraps modulo 2^32
            end else if (op == OP_MUL) begin
                result <= '0;                           // Clear the accumulator
            end else begin
                result <= operand_a + operand_b;
            end
        end else if (busy) begin
            if (mplier[0]) result <= result + mcand;    // Partial product add
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

`default_nettype wire

// File: hw/calc_control.sv
`timescale 1ns/1ps
`default_nettype none

module calc_control
    import calc_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    key_event_if.sink         events,                   // Key events from the port
    output logic              alu_start,                // One cycle start pulse
    output calc_op_t          alu_op,                   // Selected operation
    output logic [DATA_W-1:0] operand_a,
    output logic [DATA_W-1:0] operand_b,
    input  logic              alu_done,                 // Result valid strobe
    input  logic [DATA_W-1:0] alu_result,
    output logic              wr_en,                    // Store write strobe
    output logic [ADDR_W-1:0] wr_addr,
    output logic [DATA_W-1:0] wr_data,
    output logic              complete,                 // Result on display
    output logic [DISP_W-1:0] display_output
);

    typedef enum logic [1:0] {
        ST_FIRST,                                       // Entering operand A
        ST_SECOND,                                      // Entering operand B
        ST_CALC,                                        // ALU running
        ST_SHOW                                         // Showing the result
    } ctrl_state_t;

    ctrl_state_t       state;
    logic              is_digit;
    logic              is_operator;
    logic              is_equal;
    logic              is_clear;
    logic [DATA_W-1:0] accum_base;                      // Operand before the new digit
    logic [DATA_W-1:0] accum_next;                      // Operand after the new digit

    assign is_digit    = events.valid && (events.kind == KIND_DIGIT);
    assign is_operator = events.valid && (events.kind == KIND_OPERATOR);
    assign is_equal    = events.valid && (events.kind == KIND_EQUAL);
    assign is_clear    = events.valid && (events.kind == KIND_CLEAR);

    assign events.ready = (state != ST_CALC);           // Blocked while ALU works

    // Decimal accumulate, x10 as x8 plus x2
    assign accum_base = (state == ST_SECOND) ? operand_b :
                        (state == ST_SHOW)   ? '0 : operand_a;
    assign accum_next = (accum_base << 3) + (accum_base << 1) + DATA_W'(events.digit);

    // Store write port
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = ADDR_OPERAND_A;
        wr_data = accum_next;
        if (state == ST_CALC && alu_done) begin
            wr_en   = 1'b1;                             // Result lands with done
            wr_addr = ADDR_RESULT;
            wr_data = alu_result;
        end else if (is_digit) begin
            wr_en   = 1'b1;                             // New operand value
            wr_addr = (state == ST_SECOND) ? ADDR_OPERAND_B : ADDR_OPERAND_A;
        end
    end

    // Entry FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= ST_FIRST;
            operand_a      <= '0;
            operand_b      <= '0;
            alu_op         <= OP_ADD;
            alu_start      <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            alu_start <= 1'b0;
            if (events.valid) complete <= 1'b0;         // Any key ends the result phase
            if (is_clear && state != ST_CALC) begin
                state          <= ST_FIRST;
                operand_a      <= '0;
                operand_b      <= '0;
                alu_op         <= OP_ADD;
                display_output <= '0;
            end else begin
                case (state)
                    ST_FIRST: begin
                        if (is_digit) begin
                            operand_a      <= accum_next;
                            display_output <= accum_next[DISP_W-1:0];
                        end else if (is_operator) begin
                            alu_op <= events.op;
                            state  <= ST_SECOND;        // Equal here is ignored
                        end
                    end
                    ST_SECOND: begin
                        if (is_digit) begin
                            operand_b      <= accum_next;
                            display_output <= accum_next[DISP_W-1:0];
                        end else if (is_operator) begin
                            alu_op <= events.op;        // Last operator wins
                        end else if (is_equal) begin
                            alu_start <= 1'b1;
                            state     <= ST_CALC;
                        end
                    end
                    ST_CALC: begin
                        if (alu_done) begin
                            complete       <= 1'b1;
                            display_output <= alu_result[DISP_W-1:0];
                            state          <= ST_SHOW;
                        end
                    end
                    ST_SHOW: begin
                        if (is_digit) begin
                            operand_a      <= accum_next;  // Fresh first operand
                            operand_b      <= '0;
                            alu_op         <= OP_ADD;
                            display_output <= accum_next[DISP_W-1:0];
                            state          <= ST_FIRST;
                        end
                    end
                    default: state <= ST_FIRST;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/key_port.sv
`timescale 1ns/1ps
`default_nettype none

module key_port
    import calc_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             key_req,                   // Four-phase request
    input  logic [KEY_W-1:0] key_code,                  // Stable while key_req high
    output logic             key_ack,                   // Four-phase acknowledge
    key_event_if.source      events                     // Decoded key to controller
);

    typedef enum logic {
        PORT_IDLE,                                      // Waiting for a request
        PORT_ACKED                                      // Ack high until req drops
    } port_state_t;

    port_state_t state;
    logic        take;                                  // Accept the pending key
    logic        code_known;                            // Key yields an event
    key_kind_t   dec_kind;
    calc_op_t    dec_op;

    assign take    = (state == PORT_IDLE) && key_req && events.ready;
    assign key_ack = (state == PORT_ACKED);

    // Key code decode
    always_comb begin
        code_known = 1'b1;
        dec_kind   = KIND_DIGIT;
        dec_op     = OP_ADD;
        if (key_code < KEY_ADD) begin
            dec_kind = KIND_DIGIT;                      // Codes 0 to 9
        end else begin
            case (key_code)
                KEY_ADD:   dec_kind = KIND_OPERATOR;
                KEY_SUB: begin
                    dec_kind = KIND_OPERATOR;
                    dec_op   = OP_SUB;
                end
                KEY_MUL: begin
                    dec_kind = KIND_OPERATOR;
                    dec_op   = OP_MUL;
                end
                KEY_EQUAL: dec_kind = KIND_EQUAL;
                KEY_CLEAR: dec_kind = KIND_CLEAR;
                default:   code_known = 1'b0;           // Dummy key, ack only
            endcase
        end
    end

    // Handshake FSM and event strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= PORT_IDLE;
            events.valid <= 1'b0;
        end else begin
            events.valid <= take && code_known;         // Pulses with the ack rise
            case (state)
                PORT_IDLE:  if (take) state <= PORT_ACKED;
                PORT_ACKED: if (!key_req) state <= PORT_IDLE;  // Ack drops next cycle
                default:    state <= PORT_IDLE;
            endcase
        end
    end

    // Event payload
    always_ff @(posedge clk) begin
        if (take) begin
            events.kind  <= dec_kind;
            events.digit <= key_code;
            events.op    <= dec_op;
        end
    end

endmodule

`default_nettype wire

// File: hw/key_event_if.sv
`timescale 1ns/1ps
`default_nettype none

interface key_event_if
    import calc_pkg::*;
();

    logic             valid;                            // One cycle event strobe
    key_kind_t        kind;                             // Event class
    logic [KEY_W-1:0] digit;                            // Digit value
    calc_op_t         op;                               // Operator selection
    logic             ready;                            // Controller can take an event

    // Key receiver side
    modport source (output valid, kind, digit, op, input ready);

    // Controller side
    modport sink (input valid, kind, digit, op, output ready);

endinterface

`default_nettype wire

// File: hw/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // Datapath widths
    localparam int DATA_W      = 32;                    // Operand and result width
    localparam int ADDR_W      = 4;                     // Store address width
    localparam int DISP_W      = 16;                    // Display width
    localparam int STORE_DEPTH = 16;                    // Store words
    localparam int KEY_W       = 4;                     // Key code width

    // Key codes; 0 to 9 are digits, 15 is a dummy key
    localparam logic [KEY_W-1:0] KEY_ADD   = 4'd10;     // Plus
    localparam logic [KEY_W-1:0] KEY_SUB   = 4'd11;     // Minus
    localparam logic [KEY_W-1:0] KEY_MUL   = 4'd12;     // Times
    localparam logic [KEY_W-1:0] KEY_EQUAL = 4'd13;     // Equal sign
    localparam logic [KEY_W-1:0] KEY_CLEAR = 4'd14;     // Clear entry

    // Fixed store locations
    localparam logic [ADDR_W-1:0] ADDR_OPERAND_A = 4'd1;  // First operand
    localparam logic [ADDR_W-1:0] ADDR_OPERAND_B = 4'd2;  // Second operand
    localparam logic [ADDR_W-1:0] ADDR_RESULT    = 4'd3;  // Calculation result

    // Decoded key class
    typedef enum logic [1:0] {
        KIND_DIGIT    = 2'd0,                           // Numeric key
        KIND_OPERATOR = 2'd1,                           // Add, sub or mul key
        KIND_EQUAL    = 2'd2,                           // Start calculation
        KIND_CLEAR    = 2'd3                            // Reset entry
    } key_kind_t;

    // Arithmetic operation
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,                                  // a + b
        OP_SUB = 2'd1,                                  // a - b
        OP_MUL = 2'd2                                   // a * b, low word
    } calc_op_t;

endpackage

`default_nettype wire
